//--- list.f
+incdir+.
lc4_pkg.sv
lc4_decoder.sv
lc4_regfile.sv
lc4_alu.sv
lc4_lane.sv
lc4_dmem_arbiter.sv
lc4_dual_core.sv
tb_lc4_dual_core.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps -f list.f \
    --top-module tb_lc4_dual_core -o tb_lc4_dual_core

./obj_dir/tb_lc4_dual_core > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
grep -q "TEST RESULT: PASS" sim.log

//--- tb_lc4_cases.svh
    // operation codes of the case table
    localparam logic [2:0] alu_add = 3'd0;
    localparam logic [2:0] alu_sub = 3'd1;
    localparam logic [2:0] alu_mul = 3'd2;
    localparam logic [2:0] alu_and = 3'd3;
    localparam logic [2:0] alu_or = 3'd4;
    localparam logic [2:0] alu_xor = 3'd5;

    localparam int num_cases = 10;

    // a0/a1 feed lane a and b0/b1 feed lane b
    typedef struct packed {
        logic [2:0]  op;
        logic        use_load;
        logic        rnd;
        logic [15:0] a0;
        logic [15:0] a1;
        logic [15:0] b0;
        logic [15:0] b1;
        logic [7:0]  res_a;
        logic [7:0]  res_b;
        logic [7:0]  src_a;
        logic [7:0]  src_b;
        logic [15:0] exp_a;
        logic [15:0] exp_b;
    } case_row_t;

    case_row_t case_table [num_cases];

    task automatic load_case_table();
        // op, load, random, a0, a1, b0, b1, res a, res b, src a, src b, exp a, exp b
        case_table[0] = '{alu_add, 1'b0, 1'b0, 16'h1234, 16'h0f0f, 16'h8000, 16'h8001,
                          8'h40, 8'h60, 8'h00, 8'h00, 16'h2143, 16'h0001};
        case_table[1] = '{alu_sub, 1'b0, 1'b0, 16'h0005, 16'h0007, 16'h1000, 16'h0001,
                          8'h41, 8'h61, 8'h00, 8'h00, 16'hfffe, 16'h0fff};
        case_table[2] = '{alu_mul, 1'b0, 1'b0, 16'h0123, 16'h0010, 16'h00ff, 16'h0101,
                          8'h42, 8'h62, 8'h00, 8'h00, 16'h1230, 16'hffff};
        case_table[3] = '{alu_and, 1'b0, 1'b0, 16'hf0f0, 16'h3c3c, 16'hffff, 16'ha5a5,
                          8'h43, 8'h63, 8'h00, 8'h00, 16'h3030, 16'ha5a5};
        // overlapping bits so that OR differs from XOR and ADD
        case_table[4] = '{alu_or, 1'b0, 1'b0, 16'h0f00, 16'h0ff0, 16'h8001, 16'h7fff,
                          8'h44, 8'h64, 8'h00, 8'h00, 16'h0ff0, 16'hffff};
        case_table[5] = '{alu_xor, 1'b0, 1'b0, 16'haaaa, 16'h5555, 16'h1234, 16'h1234,
                          8'h45, 8'h65, 8'h00, 8'h00, 16'hffff, 16'h0000};
        case_table[6] = '{alu_add, 1'b1, 1'b0, 16'h7fff, 16'h0001, 16'hfff0, 16'h0020,
                          8'h46, 8'h66, 8'h10, 8'h20, 16'h8000, 16'h0010};
        // expected values of random rows are filled in at run time
        case_table[7] = '{alu_mul, 1'b1, 1'b1, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
                          8'h47, 8'h67, 8'h12, 8'h22, 16'h0000, 16'h0000};
        case_table[8] = '{alu_xor, 1'b0, 1'b1, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
                          8'h48, 8'h68, 8'h00, 8'h00, 16'h0000, 16'h0000};
        case_table[9] = '{alu_sub, 1'b1, 1'b1, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
                          8'h49, 8'h69, 8'h14, 8'h24, 16'h0000, 16'h0000};
    endtask

    // instruction encodings with the opcode in bits 15:12
    function automatic logic [15:0] encode_reg(input logic [3:0] opc, input logic [2:0] rd,
                                               input logic [2:0] rs, input logic [2:0] sub,
                                               input logic [2:0] rt);
        return {opc, rd, rs, sub, rt};
    endfunction

    function automatic logic [15:0] encode_mem(input logic [3:0] opc, input logic [2:0] rd,
                                               input logic [2:0] rs, input logic [5:0] imm6);
        return {opc, rd, rs, imm6};
    endfunction

    function automatic logic [15:0] encode_const(input logic [2:0] rd, input logic [8:0] imm9);
        return {4'b1001, rd, imm9};
    endfunction

    function automatic logic [15:0] encode_hiconst(input logic [2:0] rd,
                                                   input logic [7:0] uimm8);
        return {4'b1101, rd, 1'b0, uimm8};
    endfunction

    // r1 and r2 hold the operands, r3 the result, r4 the store base, r5 the load base
    task automatic build_program(input logic lane, input logic [2:0] op, input logic use_load,
                                 input logic [15:0] x, input logic [15:0] y,
                                 input logic [7:0] src, input logic [7:0] res);
        logic [3:0] opc;
        logic [2:0] sub;
        logic [2:0] n;
        case (op)
            alu_add: {opc, sub} = {4'b0001, 3'b000};
            alu_sub: {opc, sub} = {4'b0001, 3'b010};
            alu_mul: {opc, sub} = {4'b0001, 3'b001};
            alu_and: {opc, sub} = {4'b0101, 3'b000};
            alu_or:  {opc, sub} = {4'b0101, 3'b010};
            default: {opc, sub} = {4'b0101, 3'b011};
        endcase
        if (use_load) begin
            prog[lane][0] = encode_const(3'd5, {1'b0, src});
            prog[lane][1] = encode_mem(4'b0110, 3'd1, 3'd5, 6'd0);
            prog[lane][2] = encode_mem(4'b0110, 3'd2, 3'd5, 6'd1);
            n = 3'd3;
        end else begin
            prog[lane][0] = encode_const(3'd1, {1'b0, x[7:0]});
            prog[lane][1] = encode_hiconst(3'd1, x[15:8]);
            prog[lane][2] = encode_const(3'd2, {1'b0, y[7:0]});
            prog[lane][3] = encode_hiconst(3'd2, y[15:8]);
            n = 3'd4;
        end
        prog[lane][n] = encode_reg(opc, 3'd3, 3'd1, sub, 3'd2);
        prog[lane][n + 3'd1] = encode_const(3'd4, {1'b0, res});
        // store data register goes in the rd field
        prog[lane][n + 3'd2] = encode_mem(4'b0111, 3'd3, 3'd4, 6'd0);
        prog_len[lane] = {13'd0, n} + 16'd3;
    endtask

//--- tb_lc4_dual_core.sv
`timescale 1ns/10ps

module tb_lc4_dual_core;

    localparam logic [15:0] base_a = 16'h0000;
    localparam logic [15:0] base_b = 16'h0100;
    localparam int cycles_per_row = 200;

    logic        gwe = 1'b0;
    logic        i_arst_n;
    logic [15:0] o_pc_a;
    logic [15:0] i_insn_a = 16'h0000;
    logic [15:0] o_pc_b;
    logic [15:0] i_insn_b = 16'h0000;
    logic        o_mem_en;
    logic        o_mem_we;
    logic [15:0] o_mem_addr;
    logic [15:0] o_mem_wdata;
    logic [15:0] i_mem_rdata = 16'h0000;

    // data memory model and the port values seen in the middle of each cycle
    logic [15:0] mem [256];
    logic        bus_en = 1'b0;
    logic        bus_we = 1'b0;
    logic [15:0] bus_addr = 16'h0000;
    logic [15:0] bus_wdata = 16'h0000;

    // one program per lane, index 0 is lane a
    logic [15:0] prog [2][8];
    logic [15:0] prog_len [2] = '{16'd0, 16'd0};

    `include "tb_lc4_cases.svh"

    lc4_dual_core #(
        .RESET_PC_A(base_a),
        .RESET_PC_B(base_b)
    ) UUT (
        .gwe         (gwe),
        .i_arst_n    (i_arst_n),
        .o_pc_a      (o_pc_a),
        .i_insn_a    (i_insn_a),
        .o_pc_b      (o_pc_b),
        .i_insn_b    (i_insn_b),
        .o_mem_en    (o_mem_en),
        .o_mem_we    (o_mem_we),
        .o_mem_addr  (o_mem_addr),
        .o_mem_wdata (o_mem_wdata),
        .i_mem_rdata (i_mem_rdata)
    );

    always #10 gwe = ~gwe;

    task automatic report_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "check failed");
    endtask

    // wrapped 16-bit result of one row operation
    function automatic logic [15:0] op_result(input logic [2:0] op, input logic [15:0] x,
                                              input logic [15:0] y);
        logic [31:0] p;
        p = {16'd0, x} * {16'd0, y};
        case (op)
            alu_add: return x + y;
            alu_sub: return x - y;
            alu_mul: return p[15:0];
            alu_and: return x & y;
            alu_or:  return x | y;
            default: return x ^ y;
        endcase
    endfunction

    // NOP past the end of the program
    function automatic logic [15:0] fetch(input logic lane, input logic [15:0] pc,
                                          input logic [15:0] base);
        logic [15:0] idx;
        idx = pc - base;
        if (idx < prog_len[lane]) begin
            return prog[lane][idx[2:0]];
        end
        return 16'h0000;
    endfunction

    // instruction words follow the PC that the last edge produced
    always @(posedge gwe) begin
        #1;
        i_insn_a = fetch(1'b0, o_pc_a, base_a);
        i_insn_b = fetch(1'b1, o_pc_b, base_b);
    end

    always @(negedge gwe) begin
        // an access cycle is always followed by a capture cycle
        assert (!(o_mem_en && bus_en))
            else report_error("memory enable high in two consecutive cycles");
        assert (!o_mem_en || o_mem_addr[15:8] == 8'h00)
            else report_error($sformatf("memory address %h outside the model", o_mem_addr));
        bus_en = o_mem_en;
        bus_we = o_mem_we;
        bus_addr = o_mem_addr;
        bus_wdata = o_mem_wdata;
    end

    always @(posedge gwe) begin
        #1;
        if (bus_en && bus_we) begin
            mem[bus_addr[7:0]] = bus_wdata;
        end else if (bus_en) begin
            i_mem_rdata = mem[bus_addr[7:0]];
        end
    end

    task automatic check_reset_state();
        assert (o_mem_en == 1'b0 && o_pc_a == base_a && o_pc_b == base_b)
            else report_error($sformatf("reset state mem_en %b pc_a %h pc_b %h",
                                        o_mem_en, o_pc_a, o_pc_b));
    endtask

    task automatic run_row(input int k, input case_row_t row);
        @(posedge gwe);
        #1;
        i_arst_n = 1'b0;
        build_program(1'b0, row.op, row.use_load, row.a0, row.a1, row.src_a, row.res_a);
        build_program(1'b1, row.op, row.use_load, row.b0, row.b1, row.src_b, row.res_b);
        if (row.use_load) begin
            mem[row.src_a] = row.a0;
            mem[row.src_a + 8'd1] = row.a1;
            mem[row.src_b] = row.b0;
            mem[row.src_b + 8'd1] = row.b1;
        end
        repeat (3) @(posedge gwe);
        #1;
        check_reset_state();
        i_arst_n = 1'b1;
        #2;
        check_reset_state();
        // a PC passes its final store only once that store has been acked
        while (o_pc_a < base_a + prog_len[0] + 16'd1 || o_pc_b < base_b + prog_len[1] + 16'd1
               || UUT.arbiter.state_q != 2'd0) begin
            @(posedge gwe);
            #1;
        end
        assert (mem[row.res_a] == row.exp_a)
            else report_error($sformatf("row %0d lane a stored %h, expected %h",
                                        k, mem[row.res_a], row.exp_a));
        assert (mem[row.res_b] == row.exp_b)
            else report_error($sformatf("row %0d lane b stored %h, expected %h",
                                        k, mem[row.res_b], row.exp_b));
    endtask

    initial begin
        case_row_t row;
        void'($urandom(32'hcae9));
        i_arst_n = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i[7:0]] = {~i[7:0], i[7:0]};
        end
        load_case_table();
        for (int k = 0; k < num_cases; k++) begin
            row = case_table[k];
            if (row.rnd) begin
                row.a0 = 16'($urandom);
                row.a1 = 16'($urandom);
                row.b0 = 16'($urandom);
                row.b1 = 16'($urandom);
                row.exp_a = op_result(row.op, row.a0, row.a1);
                row.exp_b = op_result(row.op, row.b0, row.b1);
            end
            run_row(k, row);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

    // watchdog
    initial begin
        repeat (num_cases * cycles_per_row) @(posedge gwe);
        $display("timeout: programs did not finish within %0d cycles",
                 num_cases * cycles_per_row);
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    end

endmodule

//--- lc4_dual_core.sv
`timescale 1ns/10ps

module lc4_dual_core #(
    parameter logic [lc4_pkg::word_w-1:0] RESET_PC_A = '0,
    parameter logic [lc4_pkg::word_w-1:0] RESET_PC_B = 16'h0100
) (
    input  logic                       gwe,
    input  logic                       i_arst_n,
    output logic [lc4_pkg::word_w-1:0] o_pc_a,
    input  logic [lc4_pkg::word_w-1:0] i_insn_a,
    output logic [lc4_pkg::word_w-1:0] o_pc_b,
    input  logic [lc4_pkg::word_w-1:0] i_insn_b,
    output logic                       o_mem_en,
    output logic                       o_mem_we,
    output logic [lc4_pkg::word_w-1:0] o_mem_addr,
    output logic [lc4_pkg::word_w-1:0] o_mem_wdata,
    input  logic [lc4_pkg::word_w-1:0] i_mem_rdata
);
    import lc4_pkg::*;

    // lane to arbiter handshake, one set per lane
    logic              req_a;
    logic              we_a;
    logic [word_w-1:0] addr_a;
    logic [word_w-1:0] wdata_a;
    logic              ack_a;
    logic [word_w-1:0] rdata_a;
    logic              req_b;
    logic              we_b;
    logic [word_w-1:0] addr_b;
    logic [word_w-1:0] wdata_b;
    logic              ack_b;
    logic [word_w-1:0] rdata_b;

    lc4_lane #(.RESET_PC(RESET_PC_A)) lane_a (
        .gwe(gwe), .i_arst_n(i_arst_n), .o_pc(o_pc_a), .i_insn(i_insn_a),
        .o_req(req_a), .o_we(we_a), .o_addr(addr_a), .o_wdata(wdata_a),
        .i_ack(ack_a), .i_rdata(rdata_a)
    );

    lc4_lane #(.RESET_PC(RESET_PC_B)) lane_b (
        .gwe(gwe), .i_arst_n(i_arst_n), .o_pc(o_pc_b), .i_insn(i_insn_b),
        .o_req(req_b), .o_we(we_b), .o_addr(addr_b), .o_wdata(wdata_b),
        .i_ack(ack_b), .i_rdata(rdata_b)
    );

    lc4_dmem_arbiter arbiter (
        .gwe(gwe), .i_arst_n(i_arst_n),
        .i_req_a(req_a), .i_we_a(we_a), .i_addr_a(addr_a), .i_wdata_a(wdata_a),
        .o_ack_a(ack_a), .o_rdata_a(rdata_a),
        .i_req_b(req_b), .i_we_b(we_b), .i_addr_b(addr_b), .i_wdata_b(wdata_b),
        .o_ack_b(ack_b), .o_rdata_b(rdata_b),
        .o_mem_en(o_mem_en), .o_mem_we(o_mem_we), .o_mem_addr(o_mem_addr),
        .o_mem_wdata(o_mem_wdata), .i_mem_rdata(i_mem_rdata)
    );

endmodule

//--- lc4_dmem_arbiter.sv
`timescale 1ns/10ps

module lc4_dmem_arbiter (
    input  logic                       gwe,
    input  logic                       i_arst_n,
    input  logic                       i_req_a,
    input  logic                       i_we_a,
    input  logic [lc4_pkg::word_w-1:0] i_addr_a,
    input  logic [lc4_pkg::word_w-1:0] i_wdata_a,
    output logic                       o_ack_a,
    output logic [lc4_pkg::word_w-1:0] o_rdata_a,
    input  logic                       i_req_b,
    input  logic                       i_we_b,
    input  logic [lc4_pkg::word_w-1:0] i_addr_b,
    input  logic [lc4_pkg::word_w-1:0] i_wdata_b,
    output logic                       o_ack_b,
    output logic [lc4_pkg::word_w-1:0] o_rdata_b,
    output logic                       o_mem_en,
    output logic                       o_mem_we,
    output logic [lc4_pkg::word_w-1:0] o_mem_addr,
    output logic [lc4_pkg::word_w-1:0] o_mem_wdata,
    input  logic [lc4_pkg::word_w-1:0] i_mem_rdata
);
    import lc4_pkg::*;

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_access = 2'd1;
    localparam logic [1:0] st_capture = 2'd2;
    localparam logic [1:0] st_acked = 2'd3;

    logic [1:0]        state_q;
    // lane b when set, for both owner and last served
    logic              owner_q;
    logic              last_q;
    logic [word_w-1:0] rdata_q;
    logic              any_req;
    logic              owner_req;
    logic              pick_b;

    assign any_req = i_req_a | i_req_b;
    assign owner_req = owner_q ? i_req_b : i_req_a;
    // on a tie the lane not served last wins
    assign pick_b = i_req_b & (~i_req_a | ~last_q);

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= st_idle;
            owner_q <= 1'b0;
            last_q <= 1'b1;
        end else begin
            case (state_q)
                st_idle: begin
                    if (any_req) begin
                        owner_q <= pick_b;
                        state_q <= st_access;
                    end
                end
                st_access: state_q <= st_capture;
                st_capture: state_q <= st_acked;
                st_acked: begin
                    // owner has withdrawn req, so the port is free again
                    if (!owner_req) begin
                        last_q <= owner_q;
                        if (any_req) begin
                            owner_q <= pick_b;
                            state_q <= st_access;
                        end else begin
                            state_q <= st_idle;
                        end
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge gwe) begin
        if (state_q == st_capture) begin
            rdata_q <= i_mem_rdata;
        end
    end

    assign o_mem_en = (state_q == st_access);
    assign o_mem_we = o_mem_en & (owner_q ? i_we_b : i_we_a);
    assign o_mem_addr = owner_q ? i_addr_b : i_addr_a;
    assign o_mem_wdata = owner_q ? i_wdata_b : i_wdata_a;

    assign o_ack_a = (state_q == st_acked) & ~owner_q;
    assign o_ack_b = (state_q == st_acked) & owner_q;
    assign o_rdata_a = rdata_q;
    assign o_rdata_b = rdata_q;

endmodule

//--- lc4_lane.sv
`timescale 1ns/10ps

module lc4_lane #(
    parameter logic [lc4_pkg::word_w-1:0] RESET_PC = '0
) (
    input  logic                       gwe,
    input  logic                       i_arst_n,
    output logic [lc4_pkg::word_w-1:0] o_pc,
    input  logic [lc4_pkg::word_w-1:0] i_insn,
    output logic                       o_req,
    output logic                       o_we,
    output logic [lc4_pkg::word_w-1:0] o_addr,
    output logic [lc4_pkg::word_w-1:0] o_wdata,
    input  logic                       i_ack,
    input  logic [lc4_pkg::word_w-1:0] i_rdata
);
    import lc4_pkg::*;

    logic [word_w-1:0] pc_q;

    // decode/read stage
    lc4_insn_u            d_insn;
    logic [reg_sel_w-1:0] d_rs_sel;
    logic [reg_sel_w-1:0] d_rt_sel;
    logic [reg_sel_w-1:0] d_rd_sel;
    logic                 d_rs_re;
    logic                 d_rt_re;
    logic                 d_rd_we;
    logic                 d_is_load;
    logic                 d_is_store;
    logic [word_w-1:0]    d_rs_data;
    logic [word_w-1:0]    d_rt_data;

    // execute stage
    lc4_insn_u            x_insn;
    logic [reg_sel_w-1:0] x_rs_sel;
    logic [reg_sel_w-1:0] x_rt_sel;
    logic [reg_sel_w-1:0] x_rd_sel;
    logic                 x_rs_re;
    logic                 x_rt_re;
    logic                 x_rd_we;
    logic                 x_is_load;
    logic                 x_is_store;
    logic [word_w-1:0]    x_rs_q;
    logic [word_w-1:0]    x_rt_q;
    logic [word_w-1:0]    x_rs_fwd;
    logic [word_w-1:0]    x_rt_fwd;
    logic [word_w-1:0]    x_result;

    // writeback stage
    logic                 w_rd_we;
    logic [reg_sel_w-1:0] w_rd_sel;
    logic [word_w-1:0]    w_data;

    logic x_mem;
    logic done;
    logic stall;
    logic ack_wait_q;

    assign d_insn = i_insn;
    assign o_pc = pc_q;

    lc4_decoder u_decoder (
        .i_insn     (d_insn),
        .o_rs_sel   (d_rs_sel),
        .o_rt_sel   (d_rt_sel),
        .o_rd_sel   (d_rd_sel),
        .o_rs_re    (d_rs_re),
        .o_rt_re    (d_rt_re),
        .o_rd_we    (d_rd_we),
        .o_is_load  (d_is_load),
        .o_is_store (d_is_store)
    );

    lc4_regfile u_regfile (
        .gwe       (gwe),
        .i_arst_n  (i_arst_n),
        .i_rs_sel  (d_rs_sel),
        .i_rt_sel  (d_rt_sel),
        .o_rs_data (d_rs_data),
        .o_rt_data (d_rt_data),
        .i_rd_sel  (w_rd_sel),
        .i_rd_we   (w_rd_we),
        .i_rd_data (w_data)
    );

    // writeback to execute bypass
    assign x_rs_fwd = (x_rs_re && w_rd_we && (w_rd_sel == x_rs_sel)) ? w_data : x_rs_q;
    assign x_rt_fwd = (x_rt_re && w_rd_we && (w_rd_sel == x_rt_sel)) ? w_data : x_rt_q;

    lc4_alu u_alu (
        .i_insn   (x_insn),
        .i_rs     (x_rs_fwd),
        .i_rt     (x_rt_fwd),
        .o_result (x_result)
    );

    // req stays low until the previous ack has been withdrawn
    assign x_mem = x_is_load | x_is_store;
    assign o_req = x_mem & ~ack_wait_q;
    assign o_we = x_is_store;
    assign o_addr = x_result;
    assign o_wdata = x_rt_fwd;
    assign done = o_req & i_ack;
    assign stall = x_mem & ~done;

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q <= RESET_PC;
            x_insn <= '0;
            x_rs_sel <= '0;
            x_rt_sel <= '0;
            x_rd_sel <= '0;
            x_rs_re <= 1'b0;
            x_rt_re <= 1'b0;
            x_rd_we <= 1'b0;
            x_is_load <= 1'b0;
            x_is_store <= 1'b0;
            w_rd_we <= 1'b0;
            w_rd_sel <= '0;
            ack_wait_q <= 1'b0;
        end else begin
            ack_wait_q <= done | (ack_wait_q & i_ack);
            if (!stall) begin
                pc_q <= pc_q + 1'b1;
                x_insn <= d_insn;
                x_rs_sel <= d_rs_sel;
                x_rt_sel <= d_rt_sel;
                x_rd_sel <= d_rd_sel;
                x_rs_re <= d_rs_re;
                x_rt_re <= d_rt_re;
                x_rd_we <= d_rd_we;
                x_is_load <= d_is_load;
                x_is_store <= d_is_store;
                w_rd_we <= x_rd_we;
                w_rd_sel <= x_rd_sel;
            end else begin
                // bubble into writeback while memory is busy
                w_rd_we <= 1'b0;
            end
        end
    end

    always_ff @(posedge gwe) begin
        if (stall) begin
            // keep operands alive once writeback has moved on
            x_rs_q <= x_rs_fwd;
            x_rt_q <= x_rt_fwd;
        end else begin
            x_rs_q <= d_rs_data;
            x_rt_q <= d_rt_data;
            w_data <= x_is_load ? i_rdata : x_result;
        end
    end

endmodule

//--- lc4_alu.sv
`timescale 1ns/10ps

module lc4_alu (
    input  lc4_pkg::lc4_insn_u         i_insn,
    input  logic [lc4_pkg::word_w-1:0] i_rs,
    input  logic [lc4_pkg::word_w-1:0] i_rt,
    output logic [lc4_pkg::word_w-1:0] o_result
);
    import lc4_pkg::*;

    always_comb begin
        o_result = '0;
        case (i_insn.rform.opcode)
            op_arith: begin
                case (i_insn.rform.sub)
                    sub_add: o_result = i_rs + i_rt;
                    // product keeps only the low word
                    sub_mul: o_result = i_rs * i_rt;
                    sub_sub: o_result = i_rs - i_rt;
                    default: o_result = '0;
                endcase
            end
            op_logic: begin
                case (i_insn.rform.sub)
                    sub_and: o_result = i_rs & i_rt;
                    sub_or:  o_result = i_rs | i_rt;
                    sub_xor: o_result = i_rs ^ i_rt;
                    default: o_result = '0;
                endcase
            end
            op_const: begin
                o_result = {{(word_w-9){i_insn.cform.imm9[8]}}, i_insn.cform.imm9};
            end
            op_hiconst: begin
                o_result = {i_insn.hform.uimm8, i_rs[7:0]};
            end
            op_ldr, op_str: begin
                // effective address, base plus signed offset
                o_result = i_rs + {{(word_w-6){i_insn.mform.imm6[5]}}, i_insn.mform.imm6};
            end
            default: begin
                o_result = '0;
            end
        endcase
    end

endmodule

//--- lc4_regfile.sv
`timescale 1ns/10ps

module lc4_regfile (
    input  logic                          gwe,
    input  logic                          i_arst_n,
    input  logic [lc4_pkg::reg_sel_w-1:0] i_rs_sel,
    input  logic [lc4_pkg::reg_sel_w-1:0] i_rt_sel,
    output logic [lc4_pkg::word_w-1:0]    o_rs_data,
    output logic [lc4_pkg::word_w-1:0]    o_rt_data,
    input  logic [lc4_pkg::reg_sel_w-1:0] i_rd_sel,
    input  logic                          i_rd_we,
    input  logic [lc4_pkg::word_w-1:0]    i_rd_data
);
    import lc4_pkg::*;

    logic [word_w-1:0] regs [num_regs];

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_we) begin
            regs[i_rd_sel] <= i_rd_data;
        end
    end

    // write-through so decode sees the value retiring this cycle
    assign o_rs_data = (i_rd_we && (i_rd_sel == i_rs_sel)) ? i_rd_data : regs[i_rs_sel];
    assign o_rt_data = (i_rd_we && (i_rd_sel == i_rt_sel)) ? i_rd_data : regs[i_rt_sel];

endmodule

//--- lc4_decoder.sv
`timescale 1ns/10ps

module lc4_decoder (
    input  lc4_pkg::lc4_insn_u            i_insn,
    output logic [lc4_pkg::reg_sel_w-1:0] o_rs_sel,
    output logic [lc4_pkg::reg_sel_w-1:0] o_rt_sel,
    output logic [lc4_pkg::reg_sel_w-1:0] o_rd_sel,
    output logic                          o_rs_re,
    output logic                          o_rt_re,
    output logic                          o_rd_we,
    output logic                          o_is_load,
    output logic                          o_is_store
);
    import lc4_pkg::*;

    always_comb begin
        // anything not listed below behaves as a NOP
        o_rs_sel = '0;
        o_rt_sel = '0;
        o_rd_sel = '0;
        o_rs_re = 1'b0;
        o_rt_re = 1'b0;
        o_rd_we = 1'b0;
        o_is_load = 1'b0;
        o_is_store = 1'b0;
        case (i_insn.rform.opcode)
            op_arith, op_logic: begin
                o_rs_sel = i_insn.rform.rs;
                o_rt_sel = i_insn.rform.rt;
                o_rd_sel = i_insn.rform.rd;
                o_rs_re = 1'b1;
                o_rt_re = 1'b1;
                o_rd_we = 1'b1;
            end
            op_ldr: begin
                o_rs_sel = i_insn.mform.rs;
                o_rd_sel = i_insn.mform.rd;
                o_rs_re = 1'b1;
                o_rd_we = 1'b1;
                o_is_load = 1'b1;
            end
            op_str: begin
                // store data sits in the rd field but is read on the rt port
                o_rs_sel = i_insn.mform.rs;
                o_rt_sel = i_insn.mform.rd;
                o_rs_re = 1'b1;
                o_rt_re = 1'b1;
                o_is_store = 1'b1;
            end
            op_const: begin
                o_rd_sel = i_insn.cform.rd;
                o_rd_we = 1'b1;
            end
            op_hiconst: begin
                // keeps the low byte of rd, so rd is also a source
                o_rs_sel = i_insn.hform.rd;
                o_rd_sel = i_insn.hform.rd;
                o_rs_re = 1'b1;
                o_rd_we = 1'b1;
            end
            default: begin
                o_rd_we = 1'b0;
            end
        endcase
    end

endmodule

//--- lc4_pkg.sv
package lc4_pkg;

    // data, address and instruction width
    localparam int word_w = 16;
    localparam int reg_sel_w = 3;
    localparam int num_regs = 8;

    // major opcodes, insn[15:12]
    localparam logic [3:0] op_nop = 4'b0000;
    localparam logic [3:0] op_arith = 4'b0001;
    localparam logic [3:0] op_logic = 4'b0101;
    localparam logic [3:0] op_ldr = 4'b0110;
    localparam logic [3:0] op_str = 4'b0111;
    localparam logic [3:0] op_const = 4'b1001;
    localparam logic [3:0] op_hiconst = 4'b1101;

    // arith sub-opcodes, insn[5:3]
    localparam logic [2:0] sub_add = 3'b000;
    localparam logic [2:0] sub_mul = 3'b001;
    localparam logic [2:0] sub_sub = 3'b010;

    // logic sub-opcodes, insn[5:3]
    localparam logic [2:0] sub_and = 3'b000;
    localparam logic [2:0] sub_or = 3'b010;
    localparam logic [2:0] sub_xor = 3'b011;

    // one instruction word seen through its four encodings
    typedef union packed {
        struct packed {
            logic [3:0]           opcode;
            logic [reg_sel_w-1:0] rd;
            logic [reg_sel_w-1:0] rs;
            logic [2:0]           sub;
            logic [reg_sel_w-1:0] rt;
        } rform;
        struct packed {
            logic [3:0]           opcode;
            logic [reg_sel_w-1:0] rd;
            logic [reg_sel_w-1:0] rs;
            logic [5:0]           imm6;
        } mform;
        struct packed {
            logic [3:0]           opcode;
            logic [reg_sel_w-1:0] rd;
            logic [8:0]           imm9;
        } cform;
        struct packed {
            logic [3:0]           opcode;
            logic [reg_sel_w-1:0] rd;
            logic                 spare;
            logic [7:0]           uimm8;
        } hform;
    } lc4_insn_u;

endpackage
